//--- src.f
common/spi_cfg_pkg.sv
common/spi_cmd_pkg.sv
common/spi_job_if.sv
spi/spi_cmd_decode.sv
spi/spi_shift_engine.sv
spi/spi_read_capture.sv
hw/spi_ctrl_top.sv
bench/tb_clk_gen.sv
bench/spi_slave_model.sv
bench/tb_spi_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spi_ctrl -f src.f \
  --Mdir obj_dir -o tb_spi_ctrl

./obj_dir/tb_spi_ctrl | tee sim.log

if grep -q "Simulation completed successfully" sim.log
then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi

//--- bench/tb_spi_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module tb_spi_ctrl;

  localparam int NUM_ROWS = 26;
  localparam int TIMEOUT  = NUM_ROWS * 300 + 200;

  logic                                clk;
  logic                                rst_n;
  logic [spi_cfg_pkg::CMD_WIDTH-1:0]   cmd_in;
  logic                                cmd_vld;
  logic                                cmd_rdy;
  logic                                sclk;
  logic                                cs;
  logic                                mosi;
  logic                                miso;
  logic                                read_vld;
  logic [spi_cfg_pkg::READ_WIDTH-1:0]  read_data;
  logic                                read_rdy;
  int                                  frame_errs;

  logic [spi_cfg_pkg::CMD_WIDTH-1:0]   row_cmd [NUM_ROWS];
  int                                  row_delay [NUM_ROWS];
  logic [spi_cfg_pkg::READ_WIDTH-1:0]  row_exp [NUM_ROWS];
  logic [7:0]                          shadow [8];
  int                                  errors    = 0;
  int                                  sclk_errs = 0;
  int                                  accepted  = 0;
  int                                  cycles    = 0;

  tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

  spi_ctrl_top dut
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  spi_slave_model u_slave
  (
    .rst_n      (rst_n),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso),
    .frame_errs (frame_errs)
  );

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (rst_n && cmd_vld && cmd_rdy)
      accepted <= accepted + 1;
    if (cycles == TIMEOUT)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $finish;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && cs && sclk)
    begin
      $display("sclk is high while cs is high at %0t", $time);
      sclk_errs = sclk_errs + 1;
    end
  end

  // two reads of untouched addresses, eight writes, eight reads, four write/read pairs.
  task automatic build_table();
    logic [2:0] addr;
    logic [7:0] data;
    logic       is_wr;
    foreach (shadow[k])
      shadow[k] = 8'h00;
    addr = 3'd0;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      if (i < 2)
        addr = (i == 0) ? 3'd3 : 3'd6;
      else if (i < 10)
        addr = 3'(i - 2);
      else if (i < 18)
        addr = 3'(i - 10);
      else if (i % 2 == 0)
        addr = 3'($urandom_range(7, 0)); // odd rows read back this address.
      data  = 8'($urandom);
      is_wr = (i >= 2 && i < 10) || (i >= 18 && i % 2 == 0);
      row_delay[i] = is_wr ? 0 : int'($urandom_range(40, 0));
      if (is_wr)
      begin
        shadow[addr] = data;
        row_cmd[i]   = {1'b1, addr, data};
        row_exp[i]   = 8'h00;
      end
      else
      begin
        row_cmd[i] = {1'b0, addr, 8'h00};
        row_exp[i] = shadow[addr];
      end
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // returns one falling edge after the command was taken.
  task automatic send_cmd(input logic [spi_cfg_pkg::CMD_WIDTH-1:0] cmd);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      @(negedge clk);
    @(negedge clk);
  endtask

  task automatic take_read(input int delay, input logic [7:0] expected);
    logic [7:0] held;
    while (!read_vld)
      @(negedge clk);
    held = read_data;
    repeat (delay)
    begin
      @(negedge clk);
      if (!read_vld)
      begin
        $display("read_vld dropped at %0t before the byte was taken", $time);
        errors++;
      end
      if (read_data !== held)
      begin
        $display("** Error at %0t: read_data = %02h, held %02h", $time, read_data, held);
        errors++;
      end
    end
    if (read_data !== expected)
    begin
      $display("** Error at %0t: read_data = %02h, expected %02h", $time, read_data, expected);
      errors++;
    end
    read_rdy = 1'b1;
    @(negedge clk);
    read_rdy = 1'b0;
    compare_bit("read_vld", read_vld, 1'b0);
  endtask

  initial
  begin
    int row_start;
    int rows_ok;
    int rows_bad;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    read_rdy = 1'b0;
    rows_ok  = 0;
    rows_bad = 0;
    void'($urandom(32'h39c9_38cd));
    build_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    compare_bit("cmd_rdy", cmd_rdy, 1'b1);
    compare_bit("read_vld", read_vld, 1'b0);
    compare_bit("cs", cs, 1'b1);
    compare_bit("sclk", sclk, 1'b0);
    compare_bit("mosi", mosi, 1'b0);
    $display("reset values: %s", (errors == 0) ? "ok" : "FAILED");
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      row_start = errors;
      send_cmd(row_cmd[i]); // writes keep cmd_vld high into the next row.
      if (!row_cmd[i][spi_cmd_pkg::OP_BIT])
      begin
        cmd_vld = 1'b0;
        take_read(row_delay[i], row_exp[i]);
      end
      if (errors == row_start)
        rows_ok++;
      else
        rows_bad++;
      $display("row %2d %s addr %0d: %s", i,
               row_cmd[i][spi_cmd_pkg::OP_BIT] ? "write" : "read ",
               row_cmd[i][10:8], (errors == row_start) ? "ok" : "FAILED");
    end
    cmd_vld = 1'b0;
    if (accepted != NUM_ROWS)
    begin
      $display("commands were taken %0d times for %0d rows", accepted, NUM_ROWS);
      errors++;
    end
    errors = errors + sclk_errs + frame_errs;
    $display("rows passed %0d, rows failed %0d, errors %0d", rows_ok, rows_bad, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/spi_slave_model.sv
`default_nettype none
`timescale 1ns/1ps

module spi_slave_model
(
  input  wire  rst_n,
  input  wire  sclk,
  input  wire  cs,
  input  wire  mosi,
  output logic miso,
  output int   frame_errs
);

  logic [7:0]  regs [8];
  logic [11:0] rx_sh;
  logic [7:0]  tx_sh;
  logic [2:0]  hdr_addr;
  logic        last_hdr; // previous frame was a read header.
  int          bit_cnt;

  // sample on rising sclk, close the frame when cs goes high.
  always @(posedge sclk or posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      foreach (regs[k])
        regs[k] <= 8'h00;
      rx_sh      <= '0;
      hdr_addr   <= '0;
      last_hdr   <= 1'b0;
      bit_cnt    <= 0;
      frame_errs <= 0;
    end
    else if (cs)
    begin
      if (bit_cnt != 0)
      begin
        last_hdr <= (bit_cnt == 4);
        if (bit_cnt == 12 && rx_sh[11])
          regs[rx_sh[10:8]] <= rx_sh[7:0];
        else if (bit_cnt == 4)
          hdr_addr <= rx_sh[2:0];
        else if (bit_cnt != 8 && bit_cnt != 12)
        begin
          $display("slave: frame of %0d bits at %0t is not 12, 4 or 8 bits long",
                   bit_cnt, $time);
          frame_errs <= frame_errs + 1;
        end
      end
      bit_cnt <= 0;
    end
    else
    begin
      rx_sh   <= {rx_sh[10:0], mosi};
      bit_cnt <= bit_cnt + 1;
    end
  end

  // first bit goes out as cs falls, the rest on falling sclk.
  always @(negedge sclk or negedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      miso  <= 1'b0;
      tx_sh <= 8'h00;
    end
    else if (!cs)
    begin
      if (bit_cnt == 0)
      begin
        tx_sh <= last_hdr ? {regs[hdr_addr][6:0], 1'b0} : 8'h00;
        miso  <= last_hdr ? regs[hdr_addr][7] : 1'b0;
      end
      else
      begin
        miso  <= tx_sh[7];
        tx_sh <= tx_sh << 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clk_gen
(
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1; // released on a falling edge.
  end

endmodule

`default_nettype wire

//--- hw/spi_ctrl_top.sv
`default_nettype none
`timescale 1ns/1ps

module spi_ctrl_top
(
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire  [spi_cfg_pkg::CMD_WIDTH-1:0]   cmd_in,
  input  wire                                 cmd_vld,
  output logic                                cmd_rdy,
  output logic                                sclk,
  output logic                                cs,
  output logic                                mosi,
  input  wire                                 miso,
  output logic                                read_vld,
  output logic [spi_cfg_pkg::READ_WIDTH-1:0]  read_data,
  input  wire                                 read_rdy
);

  spi_job_if job_if ();

  logic                               rx_valid;
  logic [spi_cfg_pkg::READ_WIDTH-1:0] rx_data;
  logic                               rx_ready;

  spi_cmd_decode u_decode
  (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .cmd_rdy (cmd_rdy),
    .job     (job_if.source)
  );

  spi_shift_engine u_engine
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .job      (job_if.sink),
    .sclk     (sclk),
    .cs       (cs),
    .mosi     (mosi),
    .miso     (miso),
    .rx_valid (rx_valid),
    .rx_data  (rx_data),
    .rx_ready (rx_ready)
  );

  spi_read_capture u_capture
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (rx_valid),
    .rx_data   (rx_data),
    .rx_ready  (rx_ready),
    .read_vld  (read_vld),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

`default_nettype wire

//--- spi/spi_read_capture.sv
`default_nettype none
`timescale 1ns/1ps

module spi_read_capture
(
  input  wire                                 clk,
  input  wire                                 rst_n,
  input  wire                                 rx_valid,
  input  wire  [spi_cfg_pkg::READ_WIDTH-1:0]  rx_data,
  output logic                                rx_ready,
  output logic                                read_vld,
  output logic [spi_cfg_pkg::READ_WIDTH-1:0]  read_data,
  input  wire                                 read_rdy
);

  logic [spi_cfg_pkg::READ_WIDTH-1:0] data_q;
  logic                               full;

  assign rx_ready  = !full;
  assign read_vld  = full;
  assign read_data = data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (rx_valid && rx_ready)
    begin
      full <= 1'b1;
    end
    else if (read_vld && read_rdy)
    begin
      full <= 1'b0; // host took the byte.
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_valid && rx_ready)
    begin
      data_q <= rx_data;
    end
  end

  a_read_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (read_vld && !read_rdy) |=> (read_vld && $stable(read_data)));

endmodule

`default_nettype wire

//--- spi/spi_shift_engine.sv
`default_nettype none
`timescale 1ns/1ps

module spi_shift_engine
(
  input  wire                                 clk,
  input  wire                                 rst_n,
  spi_job_if.sink                             job,
  output logic                                sclk,
  output logic                                cs,
  output logic                                mosi,
  input  wire                                 miso,
  output logic                                rx_valid,
  output logic [spi_cfg_pkg::READ_WIDTH-1:0]  rx_data,
  input  wire                                 rx_ready
);

  spi_cmd_pkg::eng_state_e                     state;
  spi_cmd_pkg::spi_op_e                        op_q;
  logic [spi_cfg_pkg::CMD_WIDTH-1:0]           shift_q;
  logic [spi_cfg_pkg::LEN_WIDTH-1:0]           len_q;
  logic [spi_cfg_pkg::LEN_WIDTH-1:0]           bit_cnt;
  logic [$clog2(spi_cfg_pkg::SCLK_HALF)-1:0]   half_cnt;
  logic [$clog2(spi_cfg_pkg::GAP_CYCLES)-1:0]  gap_cnt;
  logic [spi_cfg_pkg::READ_WIDTH-1:0]          rx_sh;
  logic                                        half_done;
  logic                                        last_bit;

  assign job.ready = (state == spi_cmd_pkg::ST_IDLE);
  assign rx_data   = rx_sh;
  assign half_done = (half_cnt == spi_cfg_pkg::SCLK_HALF - 1);
  assign last_bit  = (bit_cnt == len_q - 1'b1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= spi_cmd_pkg::ST_IDLE;
      cs       <= 1'b1;
      sclk     <= 1'b0;
      mosi     <= 1'b0;
      rx_valid <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      case (state)
        spi_cmd_pkg::ST_IDLE:
        begin
          if (job.valid)
          begin
            op_q     <= job.op;
            len_q    <= job.tx_len;
            mosi     <= job.tx_word[spi_cfg_pkg::CMD_WIDTH-1]; // first bit at frame start.
            shift_q  <= job.tx_word << 1;
            cs       <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            state    <= spi_cmd_pkg::ST_TX;
          end
        end
        spi_cmd_pkg::ST_TX,
        spi_cmd_pkg::ST_RX:
        begin
          if (half_done)
          begin
            half_cnt <= '0;
            sclk     <= ~sclk;
            if (!sclk)
            begin
              if (state == spi_cmd_pkg::ST_RX)
              begin
                rx_sh <= {rx_sh[spi_cfg_pkg::READ_WIDTH-2:0], miso}; // rising edge.
              end
            end
            else if (last_bit)
            begin
              cs   <= 1'b1;
              mosi <= 1'b0;
              if (state == spi_cmd_pkg::ST_RX)
              begin
                rx_valid <= 1'b1;
                state    <= spi_cmd_pkg::ST_HOLD;
              end
              else if (op_q == spi_cmd_pkg::OP_WRITE)
              begin
                state <= spi_cmd_pkg::ST_DONE;
              end
              else
              begin
                gap_cnt <= '0;
                state   <= spi_cmd_pkg::ST_GAP;
              end
            end
            else
            begin
              // during rx the word is already drained, so mosi idles low.
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= shift_q[spi_cfg_pkg::CMD_WIDTH-1];
              shift_q <= shift_q << 1;
            end
          end
          else
          begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        spi_cmd_pkg::ST_GAP:
        begin
          if (gap_cnt == spi_cfg_pkg::GAP_CYCLES - 1)
          begin
            cs       <= 1'b0;
            half_cnt <= '0;
            bit_cnt  <= '0;
            len_q    <= spi_cfg_pkg::READ_WIDTH[spi_cfg_pkg::LEN_WIDTH-1:0];
            state    <= spi_cmd_pkg::ST_RX;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        spi_cmd_pkg::ST_HOLD:
        begin
          if (rx_ready)
          begin
            rx_valid <= 1'b0;
            state    <= spi_cmd_pkg::ST_DONE;
          end
        end
        spi_cmd_pkg::ST_DONE:
        begin
          state <= spi_cmd_pkg::ST_IDLE; // keeps cs high at least one cycle.
        end
        default:
        begin
          state <= spi_cmd_pkg::ST_IDLE;
        end
      endcase
    end
  end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk);
  a_rx_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (rx_valid && !rx_ready) |=> (rx_valid && $stable(rx_data)));

endmodule

`default_nettype wire

//--- spi/spi_cmd_decode.sv
`default_nettype none
`timescale 1ns/1ps

module spi_cmd_decode
(
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire [spi_cfg_pkg::CMD_WIDTH-1:0]   cmd_in,
  input  wire                                cmd_vld,
  output logic                               cmd_rdy,
  spi_job_if.source                          job
);

  logic [spi_cfg_pkg::CMD_WIDTH-1:0] cmd_q;
  logic                              full;
  logic                              is_write;

  assign is_write = cmd_q[spi_cmd_pkg::OP_BIT];
  assign cmd_rdy  = !full;
  assign job.valid = full;

  assign job.op = is_write ? spi_cmd_pkg::OP_WRITE : spi_cmd_pkg::OP_READ;

  // reads only send the top nibble as a header frame.
  assign job.tx_word = is_write ? cmd_q :
    {cmd_q[spi_cmd_pkg::OP_BIT -: spi_cfg_pkg::HDR_WIDTH],
     {(spi_cfg_pkg::CMD_WIDTH - spi_cfg_pkg::HDR_WIDTH){1'b0}}};

  assign job.tx_len = is_write ?
    spi_cfg_pkg::CMD_WIDTH[spi_cfg_pkg::LEN_WIDTH-1:0] :
    spi_cfg_pkg::HDR_WIDTH[spi_cfg_pkg::LEN_WIDTH-1:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full <= 1'b0;
    end
    else if (cmd_vld && cmd_rdy)
    begin
      full <= 1'b1;
    end
    else if (job.valid && job.ready)
    begin
      full <= 1'b0; // engine took it.
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_q <= cmd_in;
    end
  end

  // cmd_rdy and job valid never overlap.
  a_rdy_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_rdy && job.valid));

endmodule

`default_nettype wire

//--- common/spi_job_if.sv
`default_nettype none
`timescale 1ns/1ps

interface spi_job_if;

  logic                                valid;
  logic                                ready;
  spi_cmd_pkg::spi_op_e                op;
  logic [spi_cfg_pkg::CMD_WIDTH-1:0]   tx_word; // left aligned, msb goes first.
  logic [spi_cfg_pkg::LEN_WIDTH-1:0]   tx_len;

  modport source
  (
    output valid,
    output op,
    output tx_word,
    output tx_len,
    input  ready
  );

  modport sink
  (
    input  valid,
    input  op,
    input  tx_word,
    input  tx_len,
    output ready
  );

endinterface

`default_nettype wire

//--- common/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  // command bit 11 picks the operation, address in 10:8, data in 7:0.
  localparam int OP_BIT = 11;

  typedef enum logic
  {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_e;

  typedef enum logic [2:0]
  {
    ST_IDLE = 3'd0, // waiting for a job.
    ST_TX   = 3'd1, // shifting tx_word out.
    ST_GAP  = 3'd2, // cs high between read frames.
    ST_RX   = 3'd3, // shifting miso in.
    ST_HOLD = 3'd4, // read data offered to capture.
    ST_DONE = 3'd5  // one idle cycle with cs high.
  } eng_state_e;

endpackage

`default_nettype wire

//--- common/spi_cfg_pkg.sv
`default_nettype none

package spi_cfg_pkg;

  // sclk timing, in clk cycles.
  localparam int SCLK_HALF  = 5;
  localparam int GAP_CYCLES = 20; // cs high between header and data frame.

  // frame shapes.
  localparam int CMD_WIDTH  = 12;
  localparam int HDR_WIDTH  = 4;
  localparam int READ_WIDTH = 8;
  localparam int LEN_WIDTH  = 4; // holds any frame length up to 15 bits.

endpackage

`default_nettype wire
